// ==== hdl/bertChecker.sv ====
module bertChecker (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  bertPkg::bitStream_t   stream,
    regIf.regs                    bus,
    output logic                  locked
);

    logic [bertPkg::PnLength-1:0]   lfsr;
    logic [bertPkg::PnLength-1:0]   fillMask;
    logic [bertPkg::CountWidth-1:0] bitCount;
    logic [bertPkg::CountWidth-1:0] errCount;
    logic                           accept;
    logic                           expected;
    logic                           clear;

    assign accept   = enable && stream.clkEn;
    assign clear    = bus.sel && bus.wr && (bus.offset == bertPkg::BertClearReg);
    assign expected = lfsr[bertPkg::PnLength-1] ^ lfsr[bertPkg::PnTap-1];

    // Lock after a full register of received bits
    assign locked = fillMask[bertPkg::PnLength-1];

    //******************************
    // Lock and compare
    //******************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lfsr     <= '0;
            fillMask <= '0;
        end else if (clear) begin
            fillMask <= '0;
        end else if (accept) begin
            if (!locked) begin
                // Load straight from the line
                lfsr     <= {lfsr[bertPkg::PnLength-2:0], stream.data};
                fillMask <= {fillMask[bertPkg::PnLength-2:0], 1'b1};
            end else begin
                // Free running on its own state
                lfsr <= {lfsr[bertPkg::PnLength-2:0], expected};
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitCount <= '0;
            errCount <= '0;
        end else if (clear) begin
            bitCount <= '0;
            errCount <= '0;
        end else if (accept && locked) begin
            bitCount <= bitCount + 1'b1;
            if (stream.data != expected) begin
                errCount <= errCount + 1'b1;
            end
        end
    end

    //******************************
    // Readback
    //******************************
    always_comb begin
        bus.rdData = '0;
        case (bus.offset)
            bertPkg::BertStatusReg: bus.rdData[0] = locked;
            bertPkg::BertBitsLoReg: bus.rdData = bitCount[bertPkg::DataWidth-1:0];
            bertPkg::BertBitsHiReg: begin
                bus.rdData = bitCount[bertPkg::CountWidth-1:bertPkg::DataWidth];
            end
            bertPkg::BertErrsLoReg: bus.rdData = errCount[bertPkg::DataWidth-1:0];
            bertPkg::BertErrsHiReg: begin
                bus.rdData = errCount[bertPkg::CountWidth-1:bertPkg::DataWidth];
            end
            default:                bus.rdData = '0;
        endcase
    end

endmodule

// ==== hdl/bertPkg.sv ====
package bertPkg;

    //******************************
    // Bus geometry
    //******************************
    localparam int AddrWidth   = 8;
    localparam int DataWidth   = 16;
    localparam int SpaceWidth  = 4;
    localparam int OffsetWidth = AddrWidth - SpaceWidth;

    // Upper address nibble picks one of these
    localparam logic [SpaceWidth-1:0] SysSpace  = 4'd0;
    localparam logic [SpaceWidth-1:0] PnSpace   = 4'd1;
    localparam logic [SpaceWidth-1:0] BertSpace = 4'd2;

    //******************************
    // Register offsets
    //******************************
    localparam logic [OffsetWidth-1:0] SysVersionReg = 4'd0;
    localparam logic [OffsetWidth-1:0] SysControlReg = 4'd1;
    localparam logic [OffsetWidth-1:0] SysBertSelReg = 4'd2;
    localparam logic [OffsetWidth-1:0] SysOutSelReg  = 4'd3;

    localparam logic [OffsetWidth-1:0] PnRateReg   = 4'd0;
    localparam logic [OffsetWidth-1:0] PnInjectReg = 4'd1;

    localparam logic [OffsetWidth-1:0] BertStatusReg = 4'd0;
    localparam logic [OffsetWidth-1:0] BertBitsLoReg = 4'd1;
    localparam logic [OffsetWidth-1:0] BertBitsHiReg = 4'd2;
    localparam logic [OffsetWidth-1:0] BertErrsLoReg = 4'd3;
    localparam logic [OffsetWidth-1:0] BertErrsHiReg = 4'd4;
    localparam logic [OffsetWidth-1:0] BertClearReg  = 4'd5;

    localparam logic [DataWidth-1:0] VersionNumber = 16'h0a21;

    //******************************
    // Stream selectors
    //******************************
    localparam int MuxSelWidth  = 3;
    localparam int MuxSources   = 8;
    localparam int SrcPn        = 0;
    localparam int SrcSerial    = 1;
    localparam int SrcBertInput = 2;

    // x^15 + x^14 + 1
    localparam int PnLength = 15;
    localparam int PnTap    = 14;
    localparam logic [PnLength-1:0] PnSeed = '1;

    localparam int CountWidth = 32;

    // One bit per cycle where clkEn is high
    typedef struct packed {
        logic clkEn;
        logic data;
    } bitStream_t;

endpackage

// ==== hdl/bertSysTop.sv ====
module bertSysTop (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [bertPkg::AddrWidth-1:0]   busAddr,
    input  logic                            busWr,
    input  logic                            busRd,
    input  logic [bertPkg::DataWidth-1:0]   busWrData,
    output logic [bertPkg::DataWidth-1:0]   busRdData,
    input  logic                            serClk,
    input  logic                            serData,
    output logic                            lineClkOut,
    output logic                            lineDataOut,
    output logic                            bertLocked
);

    regIf sysBus ();
    regIf pnBus ();
    regIf bertBus ();

    logic                            pnEnable;
    logic                            bertEnable;
    logic [bertPkg::MuxSelWidth-1:0] bertSel;
    logic [bertPkg::MuxSelWidth-1:0] outSel;

    bertPkg::bitStream_t serialStream;
    bertPkg::bitStream_t pnStream;
    bertPkg::bitStream_t bertStream;
    bertPkg::bitStream_t lineStream;
    bertPkg::bitStream_t bertSrc [bertPkg::MuxSources];
    bertPkg::bitStream_t lineSrc [bertPkg::MuxSources];

    //******************************
    // Bus and control registers
    //******************************
    busDecoder decoder (
        .clk(clk), .rstN(rstN),
        .busAddr(busAddr), .busWr(busWr), .busRd(busRd),
        .busWrData(busWrData), .busRdData(busRdData),
        .sysBus(sysBus), .pnBus(pnBus), .bertBus(bertBus)
    );

    sysRegs topRegs (
        .clk(clk), .rstN(rstN), .bus(sysBus),
        .pnEnable(pnEnable), .bertEnable(bertEnable),
        .bertSel(bertSel), .outSel(outSel)
    );

    //******************************
    // Stream sources
    //******************************
    serialInputSync serSync (
        .clk(clk), .rstN(rstN),
        .serClk(serClk), .serData(serData), .stream(serialStream)
    );

    pnGenerator pnGen (
        .clk(clk), .rstN(rstN), .enable(pnEnable),
        .bus(pnBus), .stream(pnStream)
    );

    // Unused selector inputs stay idle
    always_comb begin
        for (int i = 0; i < bertPkg::MuxSources; i++) begin
            bertSrc[i] = '0;
            lineSrc[i] = '0;
        end
        bertSrc[bertPkg::SrcPn]        = pnStream;
        bertSrc[bertPkg::SrcSerial]    = serialStream;
        lineSrc[bertPkg::SrcPn]        = pnStream;
        lineSrc[bertPkg::SrcSerial]    = serialStream;
        lineSrc[bertPkg::SrcBertInput] = bertStream;
    end

    //******************************
    // BERT and line output
    //******************************
    clockDataMux bertMux (
        .clk(clk), .rstN(rstN), .select(bertSel),
        .sources(bertSrc), .stream(bertStream)
    );

    bertChecker bert (
        .clk(clk), .rstN(rstN), .enable(bertEnable),
        .stream(bertStream), .bus(bertBus), .locked(bertLocked)
    );

    clockDataMux lineMux (
        .clk(clk), .rstN(rstN), .select(outSel),
        .sources(lineSrc), .stream(lineStream)
    );

    assign lineClkOut  = lineStream.clkEn;
    assign lineDataOut = lineStream.data;

endmodule

// ==== hdl/busDecoder.sv ====
module busDecoder (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [bertPkg::AddrWidth-1:0]   busAddr,
    input  logic                            busWr,
    input  logic                            busRd,
    input  logic [bertPkg::DataWidth-1:0]   busWrData,
    output logic [bertPkg::DataWidth-1:0]   busRdData,
    regIf.ctrl                              sysBus,
    regIf.ctrl                              pnBus,
    regIf.ctrl                              bertBus
);

    logic [bertPkg::SpaceWidth-1:0]  space;
    logic [bertPkg::OffsetWidth-1:0] offset;
    logic [bertPkg::DataWidth-1:0]   rdMux;

    assign space  = busAddr[bertPkg::AddrWidth-1:bertPkg::OffsetWidth];
    assign offset = busAddr[bertPkg::OffsetWidth-1:0];

    //******************************
    // Space decode
    //******************************
    assign sysBus.sel  = (space == bertPkg::SysSpace);
    assign pnBus.sel   = (space == bertPkg::PnSpace);
    assign bertBus.sel = (space == bertPkg::BertSpace);

    // Blocks qualify the strobe with their own sel
    assign sysBus.wr      = busWr;
    assign sysBus.offset  = offset;
    assign sysBus.wrData  = busWrData;
    assign pnBus.wr       = busWr;
    assign pnBus.offset   = offset;
    assign pnBus.wrData   = busWrData;
    assign bertBus.wr     = busWr;
    assign bertBus.offset = offset;
    assign bertBus.wrData = busWrData;

    //******************************
    // Read data mux
    //******************************
    always_comb begin
        case (space)
            bertPkg::SysSpace:  rdMux = sysBus.rdData;
            bertPkg::PnSpace:   rdMux = pnBus.rdData;
            bertPkg::BertSpace: rdMux = bertBus.rdData;
            default:            rdMux = '0;
        endcase
    end

    // Held until the next read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busRdData <= '0;
        end else if (busRd) begin
            busRdData <= rdMux;
        end
    end

endmodule

// ==== hdl/clockDataMux.sv ====
module clockDataMux (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [bertPkg::MuxSelWidth-1:0]   select,
    input  bertPkg::bitStream_t               sources [bertPkg::MuxSources],
    output bertPkg::bitStream_t               stream
);

    // Enable and data move as one word so they never skew
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stream <= '0;
        end else begin
            stream <= sources[select];
        end
    end

endmodule

// ==== hdl/pnGenerator.sv ====
module pnGenerator (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    regIf.regs                    bus,
    output bertPkg::bitStream_t   stream
);

    logic [bertPkg::DataWidth-1:0] rate;
    logic [bertPkg::DataWidth-1:0] rateCount;
    logic [bertPkg::PnLength-1:0]  lfsr;
    logic                          feedback;
    logic                          tick;
    logic                          injectArm;
    logic                          rateWrite;
    logic                          injectWrite;

    assign rateWrite   = bus.sel && bus.wr && (bus.offset == bertPkg::PnRateReg);
    assign injectWrite = bus.sel && bus.wr && (bus.offset == bertPkg::PnInjectReg);

    //******************************
    // Registers
    //******************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rate      <= '0;
            injectArm <= 1'b0;
        end else begin
            if (rateWrite) begin
                rate <= bus.wrData;
            end
            // A new request wins over the bit that consumes the old one
            if (injectWrite) begin
                injectArm <= 1'b1;
            end else if (tick) begin
                injectArm <= 1'b0;
            end
        end
    end

    always_comb begin
        bus.rdData = '0;
        case (bus.offset)
            bertPkg::PnRateReg:   bus.rdData = rate;
            bertPkg::PnInjectReg: bus.rdData[0] = injectArm;
            default:              bus.rdData = '0;
        endcase
    end

    // Bit rate divider with the first bit right after enable
    assign tick = enable && (rateCount == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rateCount <= '0;
        end else if (!enable) begin
            rateCount <= '0;
        end else if (tick) begin
            rateCount <= rate;
        end else begin
            rateCount <= rateCount - 1'b1;
        end
    end

    //******************************
    // PN15 sequence
    //******************************
    assign feedback = lfsr[bertPkg::PnLength-1] ^ lfsr[bertPkg::PnTap-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lfsr   <= bertPkg::PnSeed;
            stream <= '0;
        end else begin
            stream.clkEn <= tick;
            if (tick) begin
                lfsr        <= {lfsr[bertPkg::PnLength-2:0], feedback};
                // Error goes on the wire only and the lfsr stays clean
                stream.data <= feedback ^ injectArm;
            end
        end
    end

endmodule

// ==== hdl/regIf.sv ====
interface regIf;

    logic                              sel;
    logic                              wr;
    logic [bertPkg::OffsetWidth-1:0]   offset;
    logic [bertPkg::DataWidth-1:0]     wrData;
    // Combinational from the block and registered in the decoder
    logic [bertPkg::DataWidth-1:0]     rdData;

    modport ctrl (
        output sel,
        output wr,
        output offset,
        output wrData,
        input  rdData
    );

    modport regs (
        input  sel,
        input  wr,
        input  offset,
        input  wrData,
        output rdData
    );

endinterface

// ==== hdl/serialInputSync.sv ====
module serialInputSync (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  serClk,
    input  logic                  serData,
    output bertPkg::bitStream_t   stream
);

    // Two flop synchronizers keep data in step with the clock
    logic [1:0] clkSync;
    logic [1:0] dataSync;
    logic       clkPrev;
    logic       clkRise;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clkSync  <= '0;
            dataSync <= '0;
            clkPrev  <= 1'b0;
        end else begin
            clkSync  <= {clkSync[0], serClk};
            dataSync <= {dataSync[0], serData};
            clkPrev  <= clkSync[1];
        end
    end

    assign clkRise = clkSync[1] && !clkPrev;

    // One clk wide enable per serial clock edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stream <= '0;
        end else begin
            stream.clkEn <= clkRise;
            if (clkRise) begin
                stream.data <= dataSync[1];
            end
        end
    end

endmodule

// ==== hdl/sysRegs.sv ====
module sysRegs (
    input  logic                              clk,
    input  logic                              rstN,
    regIf.regs                                bus,
    output logic                              pnEnable,
    output logic                              bertEnable,
    output logic [bertPkg::MuxSelWidth-1:0]   bertSel,
    output logic [bertPkg::MuxSelWidth-1:0]   outSel
);

    logic write;

    assign write = bus.sel && bus.wr;

    //******************************
    // Control and select registers
    //******************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pnEnable   <= 1'b0;
            bertEnable <= 1'b0;
            bertSel    <= '0;
            outSel     <= '0;
        end else if (write) begin
            case (bus.offset)
                bertPkg::SysControlReg: begin
                    pnEnable   <= bus.wrData[0];
                    bertEnable <= bus.wrData[1];
                end
                bertPkg::SysBertSelReg: begin
                    bertSel <= bus.wrData[bertPkg::MuxSelWidth-1:0];
                end
                bertPkg::SysOutSelReg: begin
                    outSel <= bus.wrData[bertPkg::MuxSelWidth-1:0];
                end
                default: begin
                    // Version is read only
                end
            endcase
        end
    end

    // Readback
    always_comb begin
        bus.rdData = '0;
        case (bus.offset)
            bertPkg::SysVersionReg: bus.rdData = bertPkg::VersionNumber;
            bertPkg::SysControlReg: begin
                bus.rdData[0] = pnEnable;
                bus.rdData[1] = bertEnable;
            end
            bertPkg::SysBertSelReg: bus.rdData[bertPkg::MuxSelWidth-1:0] = bertSel;
            bertPkg::SysOutSelReg:  bus.rdData[bertPkg::MuxSelWidth-1:0] = outSel;
            default:                bus.rdData = '0;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for failures
rm -rf obj_dir sim.log
verilator --binary --assert -f sources.f --top-module bertSysTb -o bertSysSim &&
    ./obj_dir/bertSysSim > sim.log 2>&1 ||
    { echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== sources.f ====
hdl/bertPkg.sv
hdl/regIf.sv
hdl/busDecoder.sv
hdl/sysRegs.sv
hdl/serialInputSync.sv
hdl/pnGenerator.sv
hdl/clockDataMux.sv
hdl/bertChecker.sv
hdl/bertSysTop.sv
verif/bertSysTb.sv

// ==== verif/bertSysTb.sv ====
module bertSysTb;

    localparam int ResetCycles  = 4;
    localparam int PulseTimeout = 200;
    localparam int LockTimeout  = 1000;
    localparam int PnCheckBits  = 40;
    localparam int CleanBits    = 64;
    localparam int InjectCount  = 4;
    localparam int SerialBits   = 24;
    localparam int SerialHalf   = 3;
    localparam logic [15:0] SelMask = 16'((1 << bertPkg::MuxSelWidth) - 1);

    logic                          clk;
    logic                          rstN;
    logic [bertPkg::AddrWidth-1:0] busAddr;
    logic                          busWr;
    logic                          busRd;
    logic [bertPkg::DataWidth-1:0] busWrData;
    logic [bertPkg::DataWidth-1:0] busRdData;
    logic                          serClk;
    logic                          serData;
    logic                          lineClkOut;
    logic                          lineDataOut;
    logic                          bertLocked;

    int          seed;
    int          errorCount;
    int          checkCount;
    int          timeoutCount;
    logic [14:0] pnState;
    logic [15:0] pnRate;
    logic        serBits [SerialBits];

    bertSysTop uut (
        .clk(clk), .rstN(rstN),
        .busAddr(busAddr), .busWr(busWr), .busRd(busRd),
        .busWrData(busWrData), .busRdData(busRdData),
        .serClk(serClk), .serData(serData),
        .lineClkOut(lineClkOut), .lineDataOut(lineDataOut),
        .bertLocked(bertLocked)
    );

    always #4 clk = ~clk;

    //******************************
    // Bus access
    //******************************
    function automatic logic [bertPkg::AddrWidth-1:0] regAddr(
        input logic [bertPkg::SpaceWidth-1:0]  space,
        input logic [bertPkg::OffsetWidth-1:0] offset
    );
        return {space, offset};
    endfunction

    task automatic busWrite(input logic [7:0] addr, input logic [15:0] data);
        @(posedge clk);
        busAddr   <= addr;
        busWrData <= data;
        busWr     <= 1'b1;
        @(posedge clk);
        busWr <= 1'b0;
    endtask

    // Read data is registered at the edge that sees busRd
    task automatic busRead(input logic [7:0] addr, output logic [15:0] data);
        @(posedge clk);
        busAddr <= addr;
        busRd   <= 1'b1;
        @(posedge clk);
        busRd <= 1'b0;
        @(negedge clk);
        data = busRdData;
    endtask

    task automatic readCount(input logic [3:0] loReg, input logic [3:0] hiReg,
                             output logic [31:0] value);
        logic [15:0] lo;
        logic [15:0] hi;
        busRead(regAddr(bertPkg::BertSpace, loReg), lo);
        busRead(regAddr(bertPkg::BertSpace, hiReg), hi);
        value = {hi, lo};
    endtask

    //******************************
    // Checks and waits
    //******************************
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkAtLeast(input string name, input logic [31:0] minimum,
                                input logic [31:0] actual);
        checkCount++;
        assert (actual >= minimum) else begin
            $display("error %s: expected at least %0d, actual %0d", name, minimum, actual);
            errorCount++;
        end
    endtask

    // Gap is the number of cycles since the previous call
    task automatic waitLinePulse(input string name, output logic data, output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!lineClkOut && gap < PulseTimeout);
        data = lineDataOut;
        if (!lineClkOut) begin
            $display("timeout in %s: no pulse seen on lineClkOut", name);
            timeoutCount++;
        end
    endtask

    task automatic waitForLock(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bertLocked && n < LockTimeout);
        if (!bertLocked) begin
            $display("timeout in %s: the BERT never locked", name);
            timeoutCount++;
        end
    endtask

    // PN15 reference for x^15 + x^14 + 1
    task automatic nextPnBit(output logic pnBit);
        logic fb;
        fb      = pnState[14] ^ pnState[13];
        pnState = {pnState[13:0], fb};
        pnBit   = fb;
    endtask

    // Data changes while serClk is low
    task automatic driveSerial();
        for (int i = 0; i < SerialBits; i++) begin
            @(posedge clk);
            serClk  <= 1'b0;
            serData <= serBits[i];
            repeat (SerialHalf) @(posedge clk);
            serClk <= 1'b1;
            repeat (SerialHalf - 1) @(posedge clk);
        end
    endtask

    //******************************
    // Stimulus
    //******************************
    initial begin
        logic        lineBit;
        logic        expBit;
        int          gap;
        logic [15:0] rdValue;
        logic [31:0] countA;
        logic [31:0] countB;
        logic [31:0] rnd;

        clk          = 1'b0;
        rstN         = 1'b0;
        busAddr      = '0;
        busWr        = 1'b0;
        busRd        = 1'b0;
        busWrData    = '0;
        serClk       = 1'b0;
        serData      = 1'b0;
        seed         = 32'hdaf890cf;
        errorCount   = 0;
        checkCount   = 0;
        timeoutCount = 0;
        pnState      = 15'h7fff;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;

        // Reset values and version
        @(negedge clk);
        checkValue("reset bertLocked", 32'd0, 32'(bertLocked));
        checkValue("reset lineClkOut", 32'd0, 32'(lineClkOut));
        busRead(regAddr(bertPkg::SysSpace, bertPkg::SysVersionReg), rdValue);
        checkValue("version", 32'(bertPkg::VersionNumber), 32'(rdValue));
        busRead(regAddr(bertPkg::SysSpace, bertPkg::SysControlReg), rdValue);
        checkValue("control after reset", 32'd0, 32'(rdValue));
        busRead(regAddr(4'd7, 4'd0), rdValue);
        checkValue("unmapped space", 32'd0, 32'(rdValue));

        // Register write and read back
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysBertSelReg), 16'hfffd);
        busRead(regAddr(bertPkg::SysSpace, bertPkg::SysBertSelReg), rdValue);
        checkValue("bertSel readback", 32'(16'hfffd & SelMask), 32'(rdValue));
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysOutSelReg), 16'h000e);
        busRead(regAddr(bertPkg::SysSpace, bertPkg::SysOutSelReg), rdValue);
        checkValue("outSel readback", 32'(16'h000e & SelMask), 32'(rdValue));
        rnd = $random(seed);
        busWrite(regAddr(bertPkg::PnSpace, bertPkg::PnRateReg), rnd[15:0]);
        busRead(regAddr(bertPkg::PnSpace, bertPkg::PnRateReg), rdValue);
        checkValue("pn rate readback", 32'(rnd[15:0]), 32'(rdValue));

        // PN sequence on the line output
        rnd    = $random(seed);
        pnRate = {13'd0, rnd[2:0]};
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysOutSelReg), 16'(bertPkg::SrcPn));
        busWrite(regAddr(bertPkg::PnSpace, bertPkg::PnRateReg), pnRate);
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysControlReg), 16'h0001);
        for (int i = 0; i < PnCheckBits; i++) begin
            waitLinePulse("pn output", lineBit, gap);
            nextPnBit(expBit);
            checkValue("pn data", 32'(expBit), 32'(lineBit));
            if (i > 0) begin
                checkValue("pn spacing", 32'(pnRate) + 32'd1, 32'(gap));
            end
        end

        // Lock, clear and a clean run
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysBertSelReg), 16'(bertPkg::SrcPn));
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysControlReg), 16'h0003);
        waitForLock("bert lock");
        busWrite(regAddr(bertPkg::BertSpace, bertPkg::BertClearReg), 16'h0001);
        waitForLock("bert relock");
        for (int i = 0; i < CleanBits; i++) begin
            waitLinePulse("clean run", lineBit, gap);
            checkValue("locked during clean run", 32'd1, 32'(bertLocked));
        end
        readCount(bertPkg::BertBitsLoReg, bertPkg::BertBitsHiReg, countA);
        checkAtLeast("clean run bit count", 32'(CleanBits), countA);
        readCount(bertPkg::BertErrsLoReg, bertPkg::BertErrsHiReg, countA);
        checkValue("clean run errors", 32'd0, countA);

        // One error per inject with two bits between injects
        for (int k = 0; k < InjectCount; k++) begin
            busWrite(regAddr(bertPkg::PnSpace, bertPkg::PnInjectReg), 16'h0001);
            waitLinePulse("error injection", lineBit, gap);
            waitLinePulse("error injection", lineBit, gap);
        end
        waitLinePulse("error injection", lineBit, gap);
        repeat (2) @(posedge clk);
        readCount(bertPkg::BertErrsLoReg, bertPkg::BertErrsHiReg, countB);
        checkValue("injected errors", 32'(InjectCount), countB - countA);

        // Serial input to both the line output and the BERT
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysControlReg), 16'h0002);
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysBertSelReg), 16'(bertPkg::SrcSerial));
        busWrite(regAddr(bertPkg::SysSpace, bertPkg::SysOutSelReg), 16'(bertPkg::SrcSerial));
        readCount(bertPkg::BertBitsLoReg, bertPkg::BertBitsHiReg, countA);
        for (int i = 0; i < SerialBits; i++) begin
            rnd        = $random(seed);
            serBits[i] = rnd[0];
        end
        fork
            driveSerial();
            for (int i = 0; i < SerialBits; i++) begin
                waitLinePulse("serial output", lineBit, gap);
                checkValue("serial data", 32'(serBits[i]), 32'(lineBit));
            end
        join
        repeat (4) @(posedge clk);
        readCount(bertPkg::BertBitsLoReg, bertPkg::BertBitsHiReg, countB);
        checkValue("serial bit count", 32'(SerialBits), countB - countA);

        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
